// ==== filelist.f ====
+incdir+rtl
+incdir+sim
rtl/cpu_pkg.sv
rtl/program_ram.sv
rtl/control_decoder.sv
rtl/alu_execute.sv
rtl/output_result.sv
rtl/cpu_top.sv
sim/tb_cpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the CPU testbench with Verilator, run it, and search the output for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f filelist.f --top-module tb_cpu -o sim_cpu \
    || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/sim_cpu)
echo "$sim_out"

echo "$sim_out" | grep -qx "Result: PASSED" \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }

// ==== sim/cpu_model.svh ====
// Reference model of the accumulator CPU instruction set and typed compare tasks, included in tb_cpu
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// Architectural state, carried from one program to the next like the DUT registers
data_t model_mem [`CPU_RAM_WORDS];  // Program image, then data after the run
data_t model_acc;
logic  model_carry;
logic  model_zero;
data_t exp_out [$];                 // Values that OUT should strobe, in order

// Runs the loaded image from address 0 until HLT
task automatic run_model();
    addr_t      pc;
    data_t      ir;
    addr_t      arg;
    logic [8:0] sum;                // Bit 8 is carry out
    int         steps;
    logic       running;
    for (int a = 0; a < `CPU_RAM_WORDS; a++)
        model_mem[addr_t'(a)] = prog_img[addr_t'(a)];
    exp_out.delete();
    pc      = '0;
    steps   = 0;
    running = 1'b1;
    while (running && steps < 4 * `CPU_RAM_WORDS) begin  // Forward jumps only, bound is loose
        ir    = model_mem[pc];
        arg   = ir[3:0];
        pc    = pc + 1'b1;          // Wraps at 16
        steps = steps + 1;
        case (ir[7:4])
            OP_LDA: model_acc = model_mem[arg];
            OP_ADD, OP_SUB: begin
                if (ir[7:4] == OP_ADD)
                    sum = {1'b0, model_acc} + {1'b0, model_mem[arg]};
                else
                    sum = {1'b0, model_acc} + {1'b0, ~model_mem[arg]} + 9'd1;  // Carry means no borrow
                model_acc   = sum[7:0];
                model_carry = sum[8];
                model_zero  = (sum[7:0] == 8'h00);
            end
            OP_STA: model_mem[arg] = model_acc;
            OP_LDI: model_acc = {4'h0, arg};
            OP_JMP: pc = arg;
            OP_JC:  if (model_carry) pc = arg;
            OP_JZ:  if (model_zero) pc = arg;
            OP_OUT: exp_out.push_back(model_acc);
            OP_HLT: running = 1'b0;
            default: ;                  // Unused opcodes do nothing
        endcase
    end
endtask

// One compare per result kind
task automatic compare_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
        $display("** Error at %0t ns: %s = 0x%02h, expected 0x%02h", $time, name, got, exp);
        stop_on_failure();
    end
endtask

task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
        stop_on_failure();
    end
endtask

`endif

// ==== sim/tb_cpu.sv ====
// Testbench for cpu_top that loads random programs through the pins and checks them against a model
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb_cpu import cpu_pkg::*; ();

    localparam int NUM_PROGS = 40;
    localparam int HALT_ADDR = 11;   // Last code word, always HLT
    localparam int DATA_BASE = 12;   // Data words 12 to 15
    localparam int WATCHDOG_CYCLES = NUM_PROGS * (12 * `CPU_TSTATES + 40) * 2;

    logic       clk;
    logic       arst_n;
    data_t      ui_in;
    logic [7:0] uio_in;
    data_t      uo_out;
    logic [7:0] uio_out;
    logic [7:0] uio_oe;
    integer     seed;
    data_t      prog_img [`CPU_RAM_WORDS];  // Image for the loader and the model

    cpu_top i_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .ui_in   (ui_in),
        .uio_in  (uio_in),
        .uo_out  (uo_out),
        .uio_out (uio_out),
        .uio_oe  (uio_oe)
    );

    task automatic stop_on_failure();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    `include "cpu_model.svh"

    // 50 MHz clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Random code in 0..10, HLT at 11, random data in 12..15
    task automatic make_program();
        int         pick;
        logic [3:0] op;
        addr_t      arg;
        for (int a = 0; a < HALT_ADDR; a++) begin
            pick = $unsigned($random(seed)) % 12;
            case (pick)
                0:         op = OP_LDA;
                1:         op = OP_ADD;
                2:         op = OP_SUB;
                3:         op = OP_STA;
                4:         op = OP_LDI;
                5:         op = OP_JMP;
                6:         op = OP_JC;
                7:         op = OP_JZ;
                8, 9, 10:  op = OP_OUT;  // Weighted up for more strobes
                default:   op = 4'h9;    // Unused code
            endcase
            if (pick <= 3)
                arg = addr_t'(DATA_BASE + $unsigned($random(seed)) % 4);     // Data words only
            else if (pick >= 5 && pick <= 7)
                arg = addr_t'(a + 1 + $unsigned($random(seed)) % (HALT_ADDR - a));  // Forward
            else
                arg = addr_t'($random(seed));
            prog_img[addr_t'(a)] = {op, arg};
        end
        prog_img[addr_t'(HALT_ADDR)] = {OP_HLT, 4'h0};
        for (int d = DATA_BASE; d < `CPU_RAM_WORDS; d++)
            prog_img[addr_t'(d)] = data_t'($random(seed));
    endtask

    // Sixteen loader writes in address order, then release prog
    task automatic load_program();
        for (int a = 0; a < `CPU_RAM_WORDS; a++) begin
            @(posedge clk);
            uio_in[`CPU_UIO_PROG] <= 1'b1;
            uio_in[`CPU_UIO_WE]   <= 1'b1;
            ui_in                 <= prog_img[addr_t'(a)];
        end
        @(posedge clk);
        uio_in <= '0;
        ui_in  <= '0;
        @(negedge clk);
        compare_flag("halted", uio_out[`CPU_UIO_HALT], 1'b0);  // Cleared by prog
    endtask

    // Checks every strobed value until halt, then the quiet halted state
    task automatic collect_outputs();
        int n;
        n = 0;
        while (uio_out[`CPU_UIO_HALT] !== 1'b1) begin
            @(negedge clk);
            if (uio_out[`CPU_UIO_STB] === 1'b1) begin
                if (n >= exp_out.size()) begin
                    $display("The CPU strobed more outputs than the %0d the model expects",
                             exp_out.size());
                    stop_on_failure();
                end
                compare_data("uo_out", uo_out, exp_out[n]);
                n = n + 1;
            end
        end
        compare_data("out_count", data_t'(n), data_t'(exp_out.size()));
        repeat (2 * `CPU_TSTATES) begin    // No strobes once halted
            @(negedge clk);
            compare_flag("out_strobe", uio_out[`CPU_UIO_STB], 1'b0);
            compare_flag("halted", uio_out[`CPU_UIO_HALT], 1'b1);
        end
        compare_flag("carry", uio_out[`CPU_UIO_CF], model_carry);
        compare_flag("zero", uio_out[`CPU_UIO_ZF], model_zero);
        for (int d = DATA_BASE; d < `CPU_RAM_WORDS; d++)
            compare_data($sformatf("mem[%0d]", d), i_dut.i_ram.mem[addr_t'(d)],
                         model_mem[addr_t'(d)]);
    endtask

    // Main sequence
    initial begin
        seed        = 32'h6c68_ed65;
        arst_n      = 1'b0;
        ui_in       = '0;
        uio_in      = '0;
        model_acc   = '0;
        model_carry = 1'b0;
        model_zero  = 1'b0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        compare_data("uo_out", uo_out, 8'h00);
        compare_data("uio_out", uio_out, 8'h00);
        compare_data("uio_oe", uio_oe, 8'h0F);
        for (int p = 0; p < NUM_PROGS; p++) begin
            make_program();
            run_model();
            load_program();
            collect_outputs();
        end
        $display("Result: PASSED");
        $finish;
    end

    // Watchdog sized from the program count
    initial begin
        repeat (16 + WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles because the CPU never halted",
                 WATCHDOG_CYCLES);
        stop_on_failure();
    end

endmodule

// ==== rtl/cpu_top.sv ====
// Top level of the accumulator CPU, wires the memory, decode, execute and result stages to the pins
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_top import cpu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  data_t      ui_in,    // Loader data
    input  logic [7:0] uio_in,   // Prog and write enable
    output data_t      uo_out,   // OUT value
    output logic [7:0] uio_out,  // Status bits
    output logic [7:0] uio_oe
);

    logic  prog;
    logic  we;
    data_t bus;           // Driven by the decoder mux only
    data_t ram_data;
    data_t acc;
    data_t alu_result;
    logic  mar_load;
    logic  ram_write;
    logic  a_load;
    logic  b_load;
    logic  alu_sub;
    logic  flags_load;
    logic  out_load;
    logic  halt_set;
    logic  carry;
    logic  zero;
    logic  out_strobe;
    logic  halted;

    assign prog = uio_in[`CPU_UIO_PROG];
    assign we   = uio_in[`CPU_UIO_WE];

    // Memory stage
    program_ram i_ram (
        .clk       (clk),
        .arst_n    (arst_n),
        .prog      (prog),
        .we        (we),
        .load_data (ui_in),
        .mar_load  (mar_load),
        .ram_write (ram_write),
        .bus       (bus),
        .ram_data  (ram_data)
    );

    // Decode stage, owns the bus
    control_decoder i_dec (
        .clk(clk), .arst_n(arst_n), .prog(prog),
        .ram_data(ram_data), .acc(acc), .alu_result(alu_result),
        .carry(carry), .zero(zero), .halted(halted),
        .bus(bus), .mar_load(mar_load), .ram_write(ram_write),
        .a_load(a_load), .b_load(b_load), .alu_sub(alu_sub),
        .flags_load(flags_load), .out_load(out_load), .halt_set(halt_set)
    );

    // Execute stage
    alu_execute i_alu (
        .clk(clk), .arst_n(arst_n), .bus(bus),
        .a_load(a_load), .b_load(b_load), .alu_sub(alu_sub), .flags_load(flags_load),
        .acc(acc), .alu_result(alu_result), .carry(carry), .zero(zero)
    );

    // Result stage
    output_result i_out (
        .clk(clk), .arst_n(arst_n), .prog(prog), .bus(bus),
        .out_load(out_load), .halt_set(halt_set),
        .out_value(uo_out), .out_strobe(out_strobe), .halted(halted)
    );

    // Status pins, upper nibble unused
    always_comb begin
        uio_out                = '0;
        uio_out[`CPU_UIO_HALT] = halted;
        uio_out[`CPU_UIO_CF]   = carry;
        uio_out[`CPU_UIO_ZF]   = zero;
        uio_out[`CPU_UIO_STB]  = out_strobe;
    end

    assign uio_oe = `CPU_UIO_OE;  // Low nibble out, high nibble in

endmodule

// ==== rtl/output_result.sv ====
// Result stage with the output register, its one-cycle strobe and the halt latch
`timescale 1ns/1ps

module output_result import cpu_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  prog,        // Clears the halt latch
    input  data_t bus,
    input  logic  out_load,    // OUT in T2
    input  logic  halt_set,    // HLT in T2
    output data_t out_value,   // Drives uo_out
    output logic  out_strobe,  // High the cycle after a load
    output logic  halted
);

    // Output register and strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_value  <= '0;
            out_strobe <= 1'b0;
        end else begin
            out_strobe <= out_load;   // Lines up with the new value
            if (out_load)
                out_value <= bus;
        end
    end

    // Halt latch, prog wins over a late HLT
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            halted <= 1'b0;
        else if (prog)
            halted <= 1'b0;
        else if (halt_set)
            halted <= 1'b1;
    end

endmodule

// ==== rtl/alu_execute.sv ====
// Execute stage with accumulator, B register, add/subtract unit and the carry and zero flags
`timescale 1ns/1ps
`include "cpu_consts.svh"

module alu_execute import cpu_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  data_t bus,
    input  logic  a_load,      // A samples bus
    input  logic  b_load,      // B samples bus
    input  logic  alu_sub,     // A+~B+1 when high
    input  logic  flags_load,  // Register carry and zero
    output data_t acc,
    output data_t alu_result,
    output logic  carry,
    output logic  zero
);

    data_t                b_reg;
    data_t                b_operand;   // B or its complement
    logic [`CPU_DATA_W:0] sum;         // Extra bit is carry out

    // Two's complement subtract through the same adder
    assign b_operand = alu_sub ? ~b_reg : b_reg;

    assign sum = {1'b0, acc}
               + {1'b0, b_operand}
               + {{`CPU_DATA_W{1'b0}}, alu_sub};  // Carry in for SUB

    assign alu_result = sum[`CPU_DATA_W-1:0];

    // Accumulator
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            acc <= '0;
        else if (a_load)
            acc <= bus;
    end

    // B register feeds only the adder
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            b_reg <= '0;
        else if (b_load)
            b_reg <= bus;
    end

    // Flags change only on ADD and SUB writeback
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            carry <= 1'b0;
            zero  <= 1'b0;
        end else if (flags_load) begin
            carry <= sum[`CPU_DATA_W];        // On SUB high means no borrow
            zero  <= (alu_result == '0);
        end
    end

    // Decoder loads A with the same result, so zero tracks A afterwards
    a_zero_matches_acc: assert property (
        @(posedge clk) disable iff (!arst_n)
        flags_load |=> (zero == (acc == '0))
    );

endmodule

// ==== rtl/control_decoder.sv ====
// Decode stage with PC, IR, T-state sequencer, control word and the internal bus multiplexer
`timescale 1ns/1ps
`include "cpu_consts.svh"

module control_decoder import cpu_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  prog,        // Hold PC at 0 and sequencer at T0
    input  data_t ram_data,
    input  data_t acc,
    input  data_t alu_result,
    input  logic  carry,       // For JC
    input  logic  zero,        // For JZ
    input  logic  halted,      // Freeze sequencer
    output data_t bus,         // Muxed internal bus
    output logic  mar_load,
    output logic  ram_write,
    output logic  a_load,
    output logic  b_load,
    output logic  alu_sub,     // Subtract select for the ALU
    output logic  flags_load,
    output logic  out_load,
    output logic  halt_set
);

    addr_t   pc;
    data_t   ir;
    tstate_e tstate;
    opcode_e opcode;
    addr_t   operand;
    logic    pc_inc;     // T1 increment
    logic    pc_load;    // Taken jump
    logic    ir_load;

    assign opcode  = opcode_e'(ir[7:4]);  // Unused codes fall to no-op
    assign operand = ir[`CPU_ADDR_W-1:0];

    // Control word and bus source
    always_comb begin
        bus        = '0;
        mar_load   = 1'b0;
        ram_write  = 1'b0;
        a_load     = 1'b0;
        b_load     = 1'b0;
        alu_sub    = 1'b0;
        flags_load = 1'b0;
        out_load   = 1'b0;
        halt_set   = 1'b0;
        pc_inc     = 1'b0;
        pc_load    = 1'b0;
        ir_load    = 1'b0;
        if (!prog && !halted) begin  // Nothing loads in prog or halt
            unique case (tstate)
                T0: begin
                    bus      = data_t'(pc);  // Zero-extended
                    mar_load = 1'b1;
                end
                T1: begin
                    bus     = ram_data;      // Fetch
                    ir_load = 1'b1;
                    pc_inc  = 1'b1;
                end
                T2: begin
                    bus = data_t'(operand);  // Default source in T2
                    case (opcode)
                        OP_LDA, OP_ADD, OP_SUB, OP_STA: mar_load = 1'b1;
                        OP_LDI: a_load  = 1'b1;
                        OP_JMP: pc_load = 1'b1;
                        OP_JC:  pc_load = carry;
                        OP_JZ:  pc_load = zero;
                        OP_OUT: begin
                            bus      = acc;
                            out_load = 1'b1;
                        end
                        OP_HLT: halt_set = 1'b1;
                        default: ;                  // No-op
                    endcase
                end
                T3: begin
                    case (opcode)
                        OP_LDA: begin
                            bus    = ram_data;
                            a_load = 1'b1;
                        end
                        OP_ADD, OP_SUB: begin
                            bus    = ram_data;      // Second operand into B
                            b_load = 1'b1;
                        end
                        OP_STA: begin
                            bus       = acc;
                            ram_write = 1'b1;
                        end
                        default: ;
                    endcase
                end
                T4: begin
                    if (opcode == OP_ADD || opcode == OP_SUB) begin
                        bus        = alu_result;
                        a_load     = 1'b1;
                        flags_load = 1'b1;
                        alu_sub    = (opcode == OP_SUB);
                    end
                end
                default: ;                          // T5 idle
            endcase
        end
    end

    // Sequencer, PC and IR
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tstate <= T0;
            pc     <= '0;
            ir     <= '0;
        end else if (prog) begin
            tstate <= T0;   // Restart from address 0 when prog falls
            pc     <= '0;
        end else if (halted) begin
            tstate <= T0;
        end else begin
            if (tstate == tstate_e'(`CPU_TSTATES - 1))
                tstate <= T0;
            else
                tstate <= tstate_e'(tstate + 3'd1);
            if (pc_load)
                pc <= bus[`CPU_ADDR_W-1:0];   // Jump target from bus
            else if (pc_inc)
                pc <= pc + 1'b1;              // Modulo 16
            if (ir_load)
                ir <= bus;
        end
    end

    // At most one register takes the bus
    a_single_bus_sink: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0({a_load, b_load, mar_load, ram_write, out_load})
    );

    // Core stays parked in T0 and only prog releases the halt latch
    a_hold_in_t0: assert property (
        @(posedge clk) disable iff (!arst_n)
        (prog || halted) |=> (tstate == T0) && (halted == $past(!prog))
    );

endmodule

// ==== rtl/program_ram.sv ====
// Memory stage holding MAR, the 16-byte RAM and the pin-driven program loader
`timescale 1ns/1ps
`include "cpu_consts.svh"

module program_ram import cpu_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  prog,       // Loader owns the write port while high
    input  logic  we,         // Loader write enable
    input  data_t load_data,  // Byte from the pins
    input  logic  mar_load,   // MAR samples bus
    input  logic  ram_write,  // STA writes bus at MAR
    input  data_t bus,
    output data_t ram_data    // Asynchronous read at MAR
);

    addr_t mar;
    addr_t load_ptr;                    // Next loader address
    data_t mem [`CPU_RAM_WORDS];        // Code and data, kept across reset

    // MAR and loader pointer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mar      <= '0;
            load_ptr <= '0;
        end else begin
            if (mar_load)
                mar <= bus[`CPU_ADDR_W-1:0];  // Address nibble only
            // Pointer sits at 0 outside prog so each entry starts at address 0
            if (!prog)
                load_ptr <= '0;
            else if (we)
                load_ptr <= load_ptr + 1'b1;  // Wraps after the last word
        end
    end

    // Single write port, loader first
    always_ff @(posedge clk) begin
        if (prog && we)
            mem[load_ptr] <= load_data;
        else if (ram_write)
            mem[mar] <= bus;
    end

    assign ram_data = mem[mar];

    // Decoder must keep STA away from the loader
    a_no_store_in_prog: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(prog && ram_write)
    );

endmodule

// ==== rtl/cpu_pkg.sv ====
// Data, address, opcode and T-state types shared by every CPU stage and the testbench
`include "cpu_consts.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0] data_t;  // One memory word or register
    typedef logic [`CPU_ADDR_W-1:0] addr_t;  // RAM address and PC

    // High nibble of each instruction byte
    typedef enum logic [3:0] {
        OP_LDA = 4'h0,  // A takes RAM
        OP_ADD = 4'h1,  // A takes A+RAM
        OP_SUB = 4'h2,  // A takes A-RAM
        OP_STA = 4'h3,  // RAM takes A
        OP_LDI = 4'h4,  // A takes operand
        OP_JMP = 4'h5,
        OP_JC  = 4'h6,  // Jump on carry
        OP_JZ  = 4'h7,  // Jump on zero
        OP_OUT = 4'hE,  // Output register takes A
        OP_HLT = 4'hF
    } opcode_e;

    // Sequencer states, six per instruction
    typedef enum logic [2:0] {
        T0,  // Address fetch
        T1,  // Instruction fetch, PC increment
        T2,  // Operand or jump
        T3,  // Memory access
        T4,  // ALU writeback
        T5   // Idle
    } tstate_e;

endpackage

// ==== rtl/cpu_consts.svh ====
// Shared width, size and pin-position constants for the accumulator CPU, included by RTL and testbench
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Word and address sizes, fixed by the one-byte instruction format
`define CPU_DATA_W     8    // Data word width
`define CPU_ADDR_W     4    // Operand nibble addresses the RAM
`define CPU_RAM_WORDS  16   // Code and data share this RAM

// Every instruction runs the full sequence
`define CPU_TSTATES    6

// Status bits on uio_out
`define CPU_UIO_HALT   0    // Halt latch
`define CPU_UIO_CF     1    // Carry flag, high means no borrow on SUB
`define CPU_UIO_ZF     2    // Zero flag
`define CPU_UIO_STB    3    // One-cycle strobe after OUT

// Control bits on uio_in
`define CPU_UIO_PROG   7    // Programming mode, core held at PC 0
`define CPU_UIO_WE     6    // Loader write enable

// Only the low nibble of uio is driven
`define CPU_UIO_OE     8'h0F

`endif
